// File: rtl/hsi_params.svh
`ifndef HSI_PARAMS_SVH
`define HSI_PARAMS_SVH

// Clocks per line bit, 2 or more
`define HSI_BIT_DIV 8

// Width of the bit-time counters
`define HSI_BIT_CNT_W 4

// Start, 8 data, parity, stop
`define HSI_FRAME_BITS 11

// Command queue entries, power of two
`define HSI_FIFO_DEPTH 4

`endif

// File: rtl/hsi_pkg.sv
package hsi_pkg;

	// One command byte as written by the host
	typedef logic [7:0] ccw_t;

	// Word recovered by the slave from the two return lines
	typedef struct packed {
		// Data bits taken from com1
		ccw_t data;
		// Even parity over data and parity bit failed
		logic parity_err;
		// Stop bit was sampled low
		logic frame_err;
		// com1 and com2 differed on at least one sample
		logic line_err;
	} rx_word_t;

endpackage

// File: rtl/ccw_gen.sv
`include "hsi_params.svh"

module ccw_gen (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          wr_en,
	input  hsi_pkg::ccw_t wr_d,
	output logic          accepted,
	output logic          full,
	output hsi_pkg::ccw_t ccw_d,
	output logic          ccw_d_rdy,
	input  logic          ccw_take
);
	import hsi_pkg::*;

	localparam int AW = $clog2(`HSI_FIFO_DEPTH);

	ccw_t          mem [`HSI_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          push;
	logic          pop;

	assign full      = (count == (AW + 1)'(`HSI_FIFO_DEPTH));
	assign ccw_d_rdy = (count != '0);
	assign ccw_d     = mem[rd_ptr];

	// Writes to a full queue are simply lost
	assign push = wr_en && !full;
	assign pop  = ccw_take && ccw_d_rdy;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wr_d;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			accepted <= 1'b0;
		end else begin
			accepted <= push;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: rtl/hsi_master.sv
`include "hsi_params.svh"

module hsi_master (
	input  logic          clk,
	input  logic          rst_n,
	input  hsi_pkg::ccw_t ccw_d,
	input  logic          ccw_d_rdy,
	output logic          ccw_take,
	output logic          tx_com1,
	output logic          tx_com2,
	output logic          tx_busy
);

	localparam int CNT_W = `HSI_BIT_CNT_W;
	localparam int IDX_W = $clog2(`HSI_FRAME_BITS);
	localparam int SR_W  = `HSI_FRAME_BITS - 1;

	logic [CNT_W-1:0] bit_cnt;
	logic [IDX_W-1:0] bit_idx;
	// Data LSB first, then parity, then stop
	logic [SR_W-1:0]  shift_q;
	logic             bit_end;
	logic             last_bit;
	logic             line_d;

	// Pick up a new byte only between frames
	assign ccw_take = !tx_busy && ccw_d_rdy;

	assign bit_end  = (bit_cnt == CNT_W'(`HSI_BIT_DIV - 1));
	assign last_bit = (bit_idx == IDX_W'(`HSI_FRAME_BITS - 1));

	// Next level for both lines
	always_comb begin
		line_d = tx_com1;
		if (ccw_take)
			line_d = 1'b0;
		else if (tx_busy && bit_end)
			line_d = last_bit ? 1'b1 : shift_q[0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_busy <= 1'b0;
			bit_cnt <= '0;
			bit_idx <= '0;
			tx_com1 <= 1'b1;
			tx_com2 <= 1'b1;
		end else begin
			// Same source bit keeps the two lines identical
			tx_com1 <= line_d;
			tx_com2 <= line_d;
			if (ccw_take) begin
				tx_busy <= 1'b1;
				bit_cnt <= '0;
				bit_idx <= '0;
			end else if (tx_busy) begin
				if (bit_end) begin
					bit_cnt <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (last_bit)
						tx_busy <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ccw_take)
			shift_q <= {1'b1, ^ccw_d, ccw_d};
		else if (tx_busy && bit_end)
			shift_q <= shift_q >> 1;
	end

endmodule

// File: rtl/hsi_slave.sv
`include "hsi_params.svh"

module hsi_slave (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              rx_com1,
	input  logic              rx_com2,
	output logic              word_valid,
	output hsi_pkg::rx_word_t word
);
	import hsi_pkg::*;

	localparam int CNT_W = `HSI_BIT_CNT_W;
	localparam int IDX_W = $clog2(`HSI_FRAME_BITS);
	localparam logic [IDX_W-1:0] STOP_IDX = IDX_W'(`HSI_FRAME_BITS - 1);
	localparam logic [IDX_W-1:0] PAR_IDX  = IDX_W'(`HSI_FRAME_BITS - 2);

	logic [1:0]       com1_sync;
	logic [1:0]       com2_sync;
	logic             com1;
	logic             com2;
	logic             com1_prev;
	logic             fall;
	logic             receiving;
	logic [CNT_W-1:0] bit_cnt;
	logic [IDX_W-1:0] bit_idx;
	logic             mid;
	logic             bit_end;
	logic             mism;
	ccw_t             data_sr;
	logic             par_acc;
	logic             line_acc;

	assign com1    = com1_sync[1];
	assign com2    = com2_sync[1];
	assign fall    = com1_prev && !com1;
	assign mid     = (bit_cnt == CNT_W'(`HSI_BIT_DIV / 2));
	assign bit_end = (bit_cnt == CNT_W'(`HSI_BIT_DIV - 1));
	assign mism    = (com1 != com2);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			com1_sync  <= 2'b11;
			com2_sync  <= 2'b11;
			com1_prev  <= 1'b1;
			receiving  <= 1'b0;
			bit_cnt    <= '0;
			bit_idx    <= '0;
			word_valid <= 1'b0;
		end else begin
			com1_sync  <= {com1_sync[0], rx_com1};
			com2_sync  <= {com2_sync[0], rx_com2};
			com1_prev  <= com1;
			word_valid <= 1'b0;
			if (!receiving) begin
				// Edge cycle counts as the first clock of the start bit
				if (fall) begin
					receiving <= 1'b1;
					bit_cnt   <= CNT_W'(1);
					bit_idx   <= '0;
				end
			end else begin
				bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
				if (mid) begin
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == '0 && com1) begin
						// Start bit gone by mid-bit, glitch
						receiving <= 1'b0;
					end else if (bit_idx == STOP_IDX) begin
						receiving  <= 1'b0;
						word_valid <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!receiving && fall) begin
			par_acc  <= 1'b0;
			line_acc <= 1'b0;
		end else if (receiving && mid) begin
			line_acc <= line_acc | mism;
			if (bit_idx != '0 && bit_idx <= PAR_IDX)
				par_acc <= par_acc ^ com1;
			if (bit_idx != '0 && bit_idx < PAR_IDX)
				data_sr <= {com1, data_sr[7:1]};
			if (bit_idx == STOP_IDX) begin
				word.data       <= data_sr;
				word.parity_err <= par_acc;
				word.frame_err  <= !com1;
				word.line_err   <= line_acc | mism;
			end
		end
	end

endmodule

// File: rtl/ccw_rx_log.sv
module ccw_rx_log (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              word_valid,
	input  hsi_pkg::rx_word_t word,
	output logic              rx_valid,
	output hsi_pkg::ccw_t     rx_d,
	output logic              rx_parity_err,
	output logic              rx_frame_err,
	output logic              rx_line_err,
	output logic [7:0]        err_cnt
);
	import hsi_pkg::*;

	rx_word_t word_q;
	logic     has_err;

	assign has_err = word.parity_err || word.frame_err || word.line_err;

	always_ff @(posedge clk) begin
		if (word_valid)
			word_q <= word;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_valid <= 1'b0;
			err_cnt  <= '0;
		end else begin
			rx_valid <= word_valid;
			// Counter sticks at its top value
			if (word_valid && has_err && err_cnt != 8'hff)
				err_cnt <= err_cnt + 1'b1;
		end
	end

	assign rx_d          = word_q.data;
	assign rx_parity_err = word_q.parity_err;
	assign rx_frame_err  = word_q.frame_err;
	assign rx_line_err   = word_q.line_err;

endmodule

// File: rtl/hsi_link_top.sv
module hsi_link_top (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          wr_en,
	input  hsi_pkg::ccw_t wr_d,
	output logic          accepted,
	output logic          full,
	output logic          tx_com1,
	output logic          tx_com2,
	output logic          tx_busy,
	input  logic          rx_com1,
	input  logic          rx_com2,
	output logic          rx_valid,
	output hsi_pkg::ccw_t rx_d,
	output logic          rx_parity_err,
	output logic          rx_frame_err,
	output logic          rx_line_err,
	output logic [7:0]    err_cnt
);
	import hsi_pkg::*;

	ccw_t     ccw_d;
	logic     ccw_d_rdy;
	logic     ccw_take;
	logic     word_valid;
	rx_word_t word;

	// Host queue feeding the transmitter
	ccw_gen ccw_gen_i (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(wr_en),
		.wr_d(wr_d),
		.accepted(accepted),
		.full(full),
		.ccw_d(ccw_d),
		.ccw_d_rdy(ccw_d_rdy),
		.ccw_take(ccw_take)
	);

	hsi_master hsi_master_i (
		.clk(clk),
		.rst_n(rst_n),
		.ccw_d(ccw_d),
		.ccw_d_rdy(ccw_d_rdy),
		.ccw_take(ccw_take),
		.tx_com1(tx_com1),
		.tx_com2(tx_com2),
		.tx_busy(tx_busy)
	);

	// Return path from the external loop
	hsi_slave hsi_slave_i (
		.clk(clk),
		.rst_n(rst_n),
		.rx_com1(rx_com1),
		.rx_com2(rx_com2),
		.word_valid(word_valid),
		.word(word)
	);

	ccw_rx_log ccw_rx_log_i (
		.clk(clk),
		.rst_n(rst_n),
		.word_valid(word_valid),
		.word(word),
		.rx_valid(rx_valid),
		.rx_d(rx_d),
		.rx_parity_err(rx_parity_err),
		.rx_frame_err(rx_frame_err),
		.rx_line_err(rx_line_err),
		.err_cnt(err_cnt)
	);

endmodule

// File: verif/hsi_link_properties.sv
module hsi_link_properties (
	input logic       clk,
	input logic       rst_n,
	input logic       tx_com1,
	input logic       tx_com2,
	input logic       tx_busy,
	input logic       rx_valid,
	input logic [7:0] err_cnt
);
	timeunit 1ns;
	timeprecision 1ps;

	// Redundant lines come from one source bit
	tx_lines_equal: assert property (
		@(posedge clk) disable iff (!rst_n) tx_com1 == tx_com2
	) else $error("tx_com1 and tx_com2 differ");

	rx_valid_single: assert property (
		@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid
	) else $error("rx_valid held for more than one cycle");

	// Saturating counter only moves up
	err_cnt_monotonic: assert property (
		@(posedge clk) disable iff (!rst_n) err_cnt >= $past(err_cnt)
	) else $error("err_cnt decreased");

	tx_idle_high: assert property (
		@(posedge clk) disable iff (!rst_n) !tx_busy |-> (tx_com1 && tx_com2)
	) else $error("tx line low while transmitter idle");

endmodule

bind hsi_link_top hsi_link_properties props_i (
	.clk(clk),
	.rst_n(rst_n),
	.tx_com1(tx_com1),
	.tx_com2(tx_com2),
	.tx_busy(tx_busy),
	.rx_valid(rx_valid),
	.err_cnt(err_cnt)
);

// File: verif/hsi_link_tb.sv
`include "hsi_params.svh"

module hsi_link_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import hsi_pkg::*;

	localparam int FAULT_NONE = 0;
	localparam int FAULT_COM2 = 1;
	localparam int FAULT_BOTH = 2;
	localparam int FAULT_STOP = 3;
	localparam int FRAME_CYCLES = `HSI_FRAME_BITS * `HSI_BIT_DIV;
	localparam int RX_TIMEOUT = 3 * FRAME_CYCLES;
	localparam int ACK_TIMEOUT = 8;

	logic       clk;
	logic       rst_n;
	logic       wr_en;
	ccw_t       wr_d;
	logic       accepted;
	logic       full;
	logic       tx_com1;
	logic       tx_com2;
	logic       tx_busy;
	logic       rx_com1 = 1'b1;
	logic       rx_com2 = 1'b1;
	logic       rx_valid;
	ccw_t       rx_d;
	logic       rx_parity_err;
	logic       rx_frame_err;
	logic       rx_line_err;
	logic [7:0] err_cnt;

	// Loopback fault control
	int   fault_mode;
	int   fault_bit;
	logic line_hold;
	int   tx_cyc;

	integer     seed;
	logic [7:0] exp_cnt;
	ccw_t       exp_d;
	ccw_t       fill_d [`HSI_FIFO_DEPTH];
	int         rnd;

	// Stimulus table columns
	ccw_t row_byte [$];
	int   row_mode [$];
	int   row_bit [$];
	logic row_par [$];
	logic row_frame [$];
	logic row_line [$];

	hsi_link_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(wr_en),
		.wr_d(wr_d),
		.accepted(accepted),
		.full(full),
		.tx_com1(tx_com1),
		.tx_com2(tx_com2),
		.tx_busy(tx_busy),
		.rx_com1(rx_com1),
		.rx_com2(rx_com2),
		.rx_valid(rx_valid),
		.rx_d(rx_d),
		.rx_parity_err(rx_parity_err),
		.rx_frame_err(rx_frame_err),
		.rx_line_err(rx_line_err),
		.err_cnt(err_cnt)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Cycles since the start bit went out
	always @(posedge clk) begin
		if (!rst_n || !tx_busy)
			tx_cyc <= 0;
		else
			tx_cyc <= tx_cyc + 1;
	end

	// Return lines, half a cycle behind the transmitter
	always @(negedge clk) begin : line_model
		int   bit_now;
		logic flip1;
		logic flip2;
		logic stop_low;
		bit_now  = tx_busy ? tx_cyc / `HSI_BIT_DIV : -1;
		flip1    = (fault_mode == FAULT_BOTH) && (bit_now == fault_bit + 1);
		flip2    = (fault_mode == FAULT_BOTH || fault_mode == FAULT_COM2) &&
			(bit_now == fault_bit + 1);
		stop_low = (fault_mode == FAULT_STOP) && (bit_now == `HSI_FRAME_BITS - 1);
		if (line_hold) begin
			rx_com1 <= 1'b1;
			rx_com2 <= 1'b1;
		end else if (stop_low) begin
			rx_com1 <= 1'b0;
			rx_com2 <= 1'b0;
		end else begin
			rx_com1 <= tx_com1 ^ flip1;
			rx_com2 <= tx_com2 ^ flip2;
		end
	end

	task automatic report_mismatch(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		$display("[FAIL] t=%0d ns %s: got %02h, expected %02h", $time, name, got, exp);
		$display("TEST FAILED");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic report_error(input string what);
		$display("Error at %0d ns: %s", $time, what);
		$display("TEST FAILED");
		$fatal(1, "%s", what);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		assert (got === exp) else report_mismatch(name, got, exp);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else report_mismatch(name, {7'd0, got}, {7'd0, exp});
	endtask

	task automatic add_row(input logic from_rand, input ccw_t b, input int mode,
		input int fbit, input logic p, input logic f, input logic l);
		int r;
		r = $random(seed);
		row_byte.push_back(from_rand ? r[7:0] : b);
		row_mode.push_back(mode);
		row_bit.push_back(fbit);
		row_par.push_back(p);
		row_frame.push_back(f);
		row_line.push_back(l);
	endtask

	// One-cycle write strobe, returns on the following falling edge
	task automatic write_byte(input ccw_t b);
		wr_en = 1'b1;
		wr_d  = b;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic wait_accepted();
		int n;
		n = 0;
		while (accepted !== 1'b1) begin
			if (n == ACK_TIMEOUT)
				report_error("write was not accepted in time");
			@(negedge clk);
			n++;
		end
	endtask

	task automatic wait_rx();
		int n;
		n = 0;
		while (rx_valid !== 1'b1) begin
			if (n == RX_TIMEOUT)
				report_error("no received word before timeout");
			@(negedge clk);
			n++;
		end
	endtask

	task automatic wait_tx_idle();
		int n;
		n = 0;
		while (tx_busy !== 1'b0) begin
			if (n == RX_TIMEOUT)
				report_error("transmitter stayed busy too long");
			@(negedge clk);
			n++;
		end
	endtask

	task automatic expect_word(input ccw_t d, input logic p, input logic f, input logic l);
		check_byte("rx_d", rx_d, d);
		check_bit("rx_parity_err", rx_parity_err, p);
		check_bit("rx_frame_err", rx_frame_err, f);
		check_bit("rx_line_err", rx_line_err, l);
		check_byte("err_cnt", err_cnt, exp_cnt);
	endtask

	initial begin
		seed       = 32'hc18718c7;
		rst_n      = 1'b0;
		wr_en      = 1'b0;
		wr_d       = '0;
		fault_mode <= FAULT_NONE;
		fault_bit  <= 0;
		line_hold  <= 1'b0;
		exp_cnt    = '0;

		// from_rand, byte, fault, data bit, parity, frame, line
		add_row(1'b0, 8'h00, FAULT_NONE, 0, 1'b0, 1'b0, 1'b0);
		add_row(1'b0, 8'hff, FAULT_NONE, 0, 1'b0, 1'b0, 1'b0);
		add_row(1'b1, 8'h00, FAULT_NONE, 0, 1'b0, 1'b0, 1'b0);
		add_row(1'b1, 8'h00, FAULT_NONE, 0, 1'b0, 1'b0, 1'b0);
		add_row(1'b1, 8'h00, FAULT_COM2, 3, 1'b0, 1'b0, 1'b1);
		add_row(1'b0, 8'hff, FAULT_COM2, 7, 1'b0, 1'b0, 1'b1);
		add_row(1'b1, 8'h00, FAULT_BOTH, 0, 1'b1, 1'b0, 1'b0);
		add_row(1'b1, 8'h00, FAULT_BOTH, 5, 1'b1, 1'b0, 1'b0);
		add_row(1'b0, 8'h00, FAULT_STOP, 0, 1'b0, 1'b1, 1'b0);
		add_row(1'b1, 8'h00, FAULT_STOP, 0, 1'b0, 1'b1, 1'b0);
		add_row(1'b1, 8'h00, FAULT_NONE, 0, 1'b0, 1'b0, 1'b0);

		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// State right after reset
		check_bit("tx_com1", tx_com1, 1'b1);
		check_bit("tx_com2", tx_com2, 1'b1);
		check_bit("tx_busy", tx_busy, 1'b0);
		check_bit("full", full, 1'b0);
		check_bit("accepted", accepted, 1'b0);
		check_bit("rx_valid", rx_valid, 1'b0);
		check_byte("err_cnt", err_cnt, 8'h00);

		for (int i = 0; i < row_byte.size(); i++) begin
			fault_mode <= row_mode[i];
			fault_bit  <= row_bit[i];
			write_byte(row_byte[i]);
			wait_accepted();
			wait_rx();
			exp_d = row_byte[i];
			// Both lines flipped corrupts the data bit itself
			if (row_mode[i] == FAULT_BOTH)
				exp_d = exp_d ^ (8'h01 << row_bit[i]);
			if ((row_par[i] || row_frame[i] || row_line[i]) && exp_cnt != 8'hff)
				exp_cnt = exp_cnt + 8'd1;
			expect_word(exp_d, row_par[i], row_frame[i], row_line[i]);
			wait_tx_idle();
		end

		// Fill the queue behind a frame that never returns
		fault_mode <= FAULT_NONE;
		line_hold  <= 1'b1;
		@(negedge clk);
		write_byte(8'h5a);
		wait_accepted();
		for (int i = 0; i < `HSI_FIFO_DEPTH; i++) begin
			rnd       = $random(seed);
			fill_d[i] = rnd[7:0];
			write_byte(fill_d[i]);
			wait_accepted();
		end
		check_bit("full", full, 1'b1);
		write_byte(8'ha5);
		check_bit("accepted", accepted, 1'b0);
		@(negedge clk);
		check_bit("accepted", accepted, 1'b0);
		check_bit("full", full, 1'b1);
		check_bit("tx_busy", tx_busy, 1'b1);

		// Release in the idle cycle between frames
		wait_tx_idle();
		line_hold <= 1'b0;
		for (int i = 0; i < `HSI_FIFO_DEPTH; i++) begin
			wait_rx();
			expect_word(fill_d[i], 1'b0, 1'b0, 1'b0);
			@(negedge clk);
		end

		$display("TEST OK");
		$finish;
	end

endmodule

// File: src.f
+incdir+rtl
rtl/hsi_pkg.sv
rtl/ccw_gen.sv
rtl/hsi_master.sv
rtl/hsi_slave.sv
rtl/ccw_rx_log.sv
rtl/hsi_link_top.sv
verif/hsi_link_properties.sv
verif/hsi_link_tb.sv

// File: Makefile
TOP := hsi_link_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f src.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir $(LOG)
